//--- files.f
rtl/lib_arbiter_pkg.sv
rtl/pixel_event_latch.sv
rtl/pixel_group_arbiter.sv
rtl/pixel_groups_l1.sv
rtl/pixel_readout_top.sv
bench/pixel_readout_sva.sv
bench/pixel_readout_tb.sv

//--- Makefile
# Verilator build and run of the pixel readout arbiter testbench

VERILATOR ?= verilator
TOP       ?= pixel_readout_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --timing --assert
JOBS      ?= 4

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# The run counts as passed only if the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "sim: pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/pixel_readout_tb.sv
/*
 * Testbench of the pixel readout arbiter
 *  - clock and reset with LCG driven event pulses
 *  - reader with a random acknowledge delay and a pending-event model
 *  - round-robin order model for a preloaded batch of events
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_readout_tb;

    import lib_arbiter_pkg::*;

    localparam int P   = PIXELS_DEF;                    // Pixels per side
    localparam int GS  = GROUP_SIZE_DEF;                // Pixels per group side
    localparam int GPS = P / GS;                        // Groups per side
    localparam int NG  = GPS * GPS;                     // Groups in the array
    localparam int NL  = GS * GS;                       // Pixels in a group
    localparam int AW  = $clog2(P);

    logic                clk;
    logic                rst_n;
    logic [P-1:0][P-1:0] event_mat;                     // Pulses into the DUT
    logic                event_ack;
    logic                event_valid;
    logic [AW-1:0]       event_x;
    logic [AW-1:0]       event_y;

    logic [P-1:0][P-1:0] pend_model;                    // Events driven but not yet read
    int                  grp_ptr [NG];                  // Last pixel read per group
    int                  top_ptr;                       // Last group read
    int                  exp_q [$];                     // Expected order as x*P+y
    int                  errors, checks, acks, hold_cnt;
    logic [31:0]         rng_state;
    logic                prev_valid, prev_acked;
    logic [AW-1:0]       prev_x, prev_y;

    pixel_readout_top UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .event_i        (event_mat),
        .event_ack_i    (event_ack),
        .event_valid_o  (event_valid),
        .event_x_o      (event_x),
        .event_y_o      (event_y)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    function automatic int rand_below(int n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[30:16]) % n;              // Upper bits are the better ones
    endfunction

    function automatic logic [P-1:0][P-1:0] random_pulses(int count);
        logic [P-1:0][P-1:0] m;
        m = '0;
        for (int i = 0; i < count; i++)
            m[rand_below(P)][rand_below(P)] = 1'b1;
        return m;
    endfunction

    function automatic int pix_row(int g, int l);
        return (g / GPS) * GS + l / GS;
    endfunction

    function automatic int pix_col(int g, int l);
        return (g % GPS) * GS + l % GS;
    endfunction

    function automatic bit group_busy(logic [P-1:0][P-1:0] m, int g);
        bit any;
        any = 1'b0;
        for (int l = 0; l < NL; l++)
            any |= m[pix_row(g, l)][pix_col(g, l)];
        return any;
    endfunction

    // Round-robin search in row-major order after the last grant
    function automatic int next_local(logic [P-1:0][P-1:0] m, int g, int last);
        int cand;
        for (int i = 1; i <= NL; i++)
        begin
            cand = (last + i) % NL;
            if (m[pix_row(g, cand)][pix_col(g, cand)])
                return cand;
        end
        return -1;
    endfunction

    function automatic int next_group(logic [P-1:0][P-1:0] m, int last);
        int cand;
        for (int i = 1; i <= NG; i++)
        begin
            cand = (last + i) % NG;
            if (group_busy(m, cand))
                return cand;
        end
        return -1;
    endfunction

    task automatic compare(string name, int actual, int expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    // Whole group drains before the top level moves to the next group
    task automatic build_order();
        logic [P-1:0][P-1:0] work;
        int gp [NG];
        int tp, g, l;
        work = pend_model;
        gp   = grp_ptr;
        tp   = top_ptr;
        g    = -1;
        exp_q.delete();
        for (int n = 0; n < P * P && work != '0; n++)
        begin
            if (g < 0 || !group_busy(work, g))
            begin
                g  = next_group(work, tp);
                tp = g;
            end
            l     = next_local(work, g, gp[g]);
            gp[g] = l;
            work[pix_row(g, l)][pix_col(g, l)] = 1'b0;
            exp_q.push_back(pix_row(g, l) * P + pix_col(g, l));
        end
    endtask

    // Checks outputs, runs the reader and drives the inputs for one clock cycle
    task automatic step(logic [P-1:0][P-1:0] pulses, bit reader_on);
        int  x, y, g;
        bit  ack;
        x   = int'(event_x);
        y   = int'(event_y);
        ack = 1'b0;
        if (prev_valid && !prev_acked)
        begin
            compare("event_valid_o held", int'(event_valid), 1);
            compare("event_x_o held", x, int'(prev_x));
            compare("event_y_o held", y, int'(prev_y));
        end
        if (pend_model == '0)
            compare("event_valid_o with nothing pending", int'(event_valid), 0);
        if (event_valid && reader_on)
        begin
            if (hold_cnt > 0)
                hold_cnt--;
            else
                ack = 1'b1;
        end
        if (ack)
        begin
            compare("pending model at event_x_o/event_y_o", int'(pend_model[x][y]), 1);
            if (exp_q.size() > 0)
                compare("event_x_o*P+event_y_o order", x * P + y, exp_q.pop_front());
            pend_model[x][y] = 1'b0;
            g          = (x / GS) * GPS + y / GS;
            grp_ptr[g] = (x % GS) * GS + y % GS;
            top_ptr    = g;
            hold_cnt   = rand_below(4);                 // Delay for the next event
            acks++;
        end
        pend_model |= pulses;                           // Applied after the clear so a pulse wins
        prev_valid = event_valid;
        prev_acked = ack;
        prev_x     = event_x;
        prev_y     = event_y;
        event_ack  = ack;
        event_mat  = pulses;
        @(negedge clk);
    endtask

    task automatic drain(int limit);
        int n, quiet;
        n     = 0;
        quiet = 0;
        while (quiet < 8 && n < limit)
        begin
            if (event_valid || pend_model != '0)
                quiet = 0;
            else
                quiet++;
            step('0, 1'b1);
            n++;
        end
        if (quiet < 8)
        begin
            errors++;
            $display("ERROR: events still pending after %0d cycles", limit);
        end
        compare("pending model count", $countones(pend_model), 0);
    endtask

    task automatic wait_valid(int limit);
        int n;
        n = 0;
        while (!event_valid && n < limit)
        begin
            step('0, 1'b0);
            n++;
        end
        if (!event_valid)
        begin
            errors++;
            $display("ERROR: no event presented within %0d cycles", limit);
        end
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        event_mat = '0;
        event_ack = 1'b0;
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            compare("event_valid_o in reset", int'(event_valid), 0);
        end
        rst_n      = 1'b1;
        pend_model = '0;
        top_ptr    = NG - 1;                            // First search starts at index 0
        foreach (grp_ptr[i])
            grp_ptr[i] = NL - 1;
        prev_valid = 1'b0;
        prev_acked = 1'b0;
        hold_cnt   = 0;
    endtask

    task automatic end_test(int num, string name, int mark);
        $display("test %0d %s finished with %0d errors", num, name, errors - mark);
    endtask

    initial
    begin
        logic [P-1:0][P-1:0] pulses;
        int mark, x, y;
        rng_state = 32'hb007;
        errors    = 0;
        checks    = 0;
        acks      = 0;
        rst_n     = 1'b0;
        event_mat = '0;
        event_ack = 1'b0;

        mark = errors;
        apply_reset();
        for (int i = 0; i < 6; i++)
            step('0, 1'b1);                             // Nothing pending so valid stays low
        end_test(1, "reset state", mark);

        mark = errors;
        x = rand_below(P);
        y = rand_below(P);
        pulses = '0;
        pulses[x][y] = 1'b1;
        step(pulses, 1'b0);
        compare("event_valid_o 1 cycle after pulse", int'(event_valid), 0);
        step('0, 1'b0);
        compare("event_valid_o 2 cycles after pulse", int'(event_valid), 0);
        step('0, 1'b0);
        compare("event_valid_o 3 cycles after pulse", int'(event_valid), 1);
        compare("event_x_o", int'(event_x), x);
        compare("event_y_o", int'(event_y), y);
        drain(50);
        end_test(2, "single event", mark);

        mark = errors;
        for (int i = 0; i < 200; i++)
            step((rand_below(4) == 0) ? random_pulses(1 + rand_below(2)) : '0, 1'b1);
        drain(400);
        end_test(3, "random burst", mark);

        mark = errors;
        for (int r = 0; r < 3; r++)
        begin
            step(random_pulses(6 + rand_below(6)), 1'b1);
            build_order();                              // All events latched together
            drain(400);
            compare("expected events left", exp_q.size(), 0);
        end
        end_test(4, "round-robin order", mark);

        mark = errors;
        for (int r = 0; r < 4; r++)
        begin
            step(random_pulses(3), 1'b1);
            wait_valid(20);
            for (int h = 4 + rand_below(16); h > 0; h--)
            begin
                pulses = random_pulses(rand_below(2));
                if (rand_below(2) == 0)
                    pulses[event_x][event_y] = 1'b1;    // Repeat on the presented pixel
                step(pulses, 1'b0);
            end
            drain(400);
        end
        end_test(5, "back-pressure", mark);

        errors += UUT.u_sva.fail_count;
        $display("%0d checks, %0d errors, %0d events read", checks, errors, acks);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : pixel_readout_tb

`default_nettype wire

//--- bench/pixel_readout_sva.sv
/*
 * Concurrent assertions on the readout top level
 *  - pixel and group grants one-hot or zero
 *  - event address frozen while valid waits for the acknowledge
 *  - no valid event during reset
 *  - pixel grant only inside the enabled group
 *  - running count of failed assertions
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_readout_sva #(
    parameter  int PIXELS     = lib_arbiter_pkg::PIXELS_DEF,      // Pixels per array side
    parameter  int GROUP_SIZE = lib_arbiter_pkg::GROUP_SIZE_DEF,  // Pixels per group side
    localparam int GROUPS     = PIXELS / GROUP_SIZE,              // Groups per side
    localparam int ADD_W      = (PIXELS > 1) ? $clog2(PIXELS) : 1 // Address width
) (
    input  wire logic                           clk_i,          // Clock
    input  wire logic                           rst_n_i,        // Async reset, active low
    input  wire logic [PIXELS-1:0][PIXELS-1:0]  pix_gnt_i,      // Full-size pixel grant
    input  wire logic [GROUPS-1:0][GROUPS-1:0]  grp_gnt_i,      // Top arbiter group grant
    input  wire logic                           event_ack_i,    // Reader acknowledge
    input  wire logic                           event_valid_i,  // Event presented
    input  wire logic [ADD_W-1:0]               event_x_i,      // Event row
    input  wire logic [ADD_W-1:0]               event_y_i       // Event column
);

    logic [PIXELS-1:0][PIXELS-1:0] enabled_mask;                 // Pixels of the enabled group
    int                            fail_count = 0;               // Failed assertions so far

    always_comb
    begin
        for (int r = 0; r < PIXELS; r++)
        begin
            for (int c = 0; c < PIXELS; c++)
            begin
                enabled_mask[r][c] = grp_gnt_i[r / GROUP_SIZE][c / GROUP_SIZE];
            end
        end
    end

    a_pix_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(pix_gnt_i))
        else
        begin
            $error("pixel grant is not one-hot or zero");
            fail_count++;
        end

    a_grp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grp_gnt_i))
        else
        begin
            $error("group grant is not one-hot or zero");
            fail_count++;
        end

    // Back-pressure freezes the presented event
    a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        event_valid_i && !event_ack_i |=>
            event_valid_i && $stable(event_x_i) && $stable(event_y_i))
        else
        begin
            $error("event changed while waiting for the acknowledge");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> !event_valid_i)
        else
        begin
            $error("event valid during reset");
            fail_count++;
        end

    // A group arbiter holding a grant must still be enabled
    a_enabled_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|pix_gnt_i) |-> ((pix_gnt_i & ~enabled_mask) == '0))
        else
        begin
            $error("pixel grant held by a disabled group");
            fail_count++;
        end

endmodule : pixel_readout_sva

bind pixel_readout_top pixel_readout_sva #(
    .PIXELS         (PIXELS),
    .GROUP_SIZE     (GROUP_SIZE)
) u_sva (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .pix_gnt_i      (pix_gnt),
    .grp_gnt_i      (grp_gnt),
    .event_ack_i    (event_ack_i),
    .event_valid_i  (event_valid_o),
    .event_x_i      (event_x_o),
    .event_y_i      (event_y_o)
);

`default_nettype wire

//--- rtl/pixel_readout_top.sv
/*
 * Readout arbiter of an event-driven pixel array
 *  - sticky event latch in front of two arbitration levels
 *  - group level picks a pixel inside the enabled group
 *  - top arbiter picks one requesting group
 *  - valid/acknowledge event port with full-array row and column
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_readout_top #(
    parameter  int PIXELS     = lib_arbiter_pkg::PIXELS_DEF,      // Pixels per array side
    parameter  int GROUP_SIZE = lib_arbiter_pkg::GROUP_SIZE_DEF,  // Pixels per group side
    localparam int ADD_W      = (PIXELS > 1) ? $clog2(PIXELS) : 1 // Address width
) (
    input  wire logic                           clk_i,          // Clock
    input  wire logic                           rst_n_i,        // Async reset, active low
    input  wire logic [PIXELS-1:0][PIXELS-1:0]  event_i,        // Event pulse matrix
    input  wire logic                           event_ack_i,    // Reader accepts the event
    output logic                                event_valid_o,  // Event presented
    output logic      [ADD_W-1:0]               event_x_o,      // Row of the event
    output logic      [ADD_W-1:0]               event_y_o       // Column of the event
);

    localparam int GROUPS = PIXELS / GROUP_SIZE;                 // Groups per side

    logic [PIXELS-1:0][PIXELS-1:0] pending;                      // Latched events
    logic [PIXELS-1:0][PIXELS-1:0] pix_gnt;                      // Presented pixel
    logic [GROUPS-1:0][GROUPS-1:0] grp_req;                      // Groups with pending pixels
    logic [GROUPS-1:0][GROUPS-1:0] grp_gnt;                      // Enabled group
    logic                          grp_release;                  // Enabled group emptied

    pixel_event_latch #(
        .PIXELS         (PIXELS)
    ) u_latch (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .event_i        (event_i),
        .clear_i        (pix_gnt),                               // Retire the presented pixel
        .ack_i          (event_ack_i),
        .pending_o      (pending)
    );

    pixel_groups_l1 #(
        .PIXELS         (PIXELS),
        .GROUP_SIZE     (GROUP_SIZE)
    ) u_groups (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .set_i          (pending),
        .gnt_top_i      (grp_gnt),
        .grp_release_i  (event_ack_i),                           // Handshake releases the pixel
        .req_o          (grp_req),
        .gnt_o_high     (pix_gnt),
        .x_add_o        (event_x_o),
        .y_add_o        (event_y_o),
        .active_o       (event_valid_o),                         // Held pixel grant is the valid
        .grp_release_o  (grp_release)
    );

    // Top level arbiter over the group matrix, always enabled
    pixel_group_arbiter #(
        .SIZE           (GROUPS)
    ) u_top_arb (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .enable_i       (1'b1),
        .req_i          (grp_req),
        .grp_release_i  (grp_release),                           // Moves on once a group is empty
        .req_o          (),
        .gnt_o          (grp_gnt),
        .x_add_o        (),
        .y_add_o        (),
        .active_o       (),
        .grp_release_o  ()
    );

endmodule : pixel_readout_top

`default_nettype wire

//--- rtl/pixel_groups_l1.sv
/*
 * Group level of the readout arbiter
 *  - tiles the pixel matrix into square groups
 *  - one round-robin arbiter per group, enabled by the top grant
 *  - merges group grants into a full-size grant matrix
 *  - muxes address and release of the enabled group
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_groups_l1 #(
    parameter  int PIXELS     = lib_arbiter_pkg::PIXELS_DEF,     // Pixels per array side
    parameter  int GROUP_SIZE = lib_arbiter_pkg::GROUP_SIZE_DEF, // Pixels per group side
    localparam int GROUPS     = PIXELS / GROUP_SIZE,             // Groups per side
    localparam int ADD_W      = (PIXELS > 1) ? $clog2(PIXELS) : 1 // Array address width
) (
    input  wire logic                           clk_i,          // Clock
    input  wire logic                           rst_n_i,        // Async reset, active low
    input  wire logic [PIXELS-1:0][PIXELS-1:0]  set_i,          // Pending pixel matrix
    input  wire logic [GROUPS-1:0][GROUPS-1:0]  gnt_top_i,      // One-hot group enable
    input  wire logic                           grp_release_i,  // Reader acknowledge
    output logic      [GROUPS-1:0][GROUPS-1:0]  req_o,          // One request per group
    output logic      [PIXELS-1:0][PIXELS-1:0]  gnt_o_high,     // Full-size pixel grant
    output logic      [ADD_W-1:0]               x_add_o,        // Row in the full array
    output logic      [ADD_W-1:0]               y_add_o,        // Column in the full array
    output logic                                active_o,       // Some group holds a grant
    output logic                                grp_release_o   // Enabled group is done
);

    localparam int NUM_GROUPS = GROUPS * GROUPS;                 // Total groups
    localparam int LOC_W      = (GROUP_SIZE > 1) ? $clog2(GROUP_SIZE) : 1;

    logic [NUM_GROUPS-1:0]             gnt_top_flat;             // Group enables, row-major
    logic [NUM_GROUPS-1:0]             req_flat;                 // Group requests, row-major
    logic [NUM_GROUPS-1:0]             act_flat;                 // Per-group active
    logic [NUM_GROUPS-1:0]             rel_flat;                 // Per-group release
    logic [NUM_GROUPS-1:0][ADD_W-1:0]  x_full;                   // Per-group full row
    logic [NUM_GROUPS-1:0][ADD_W-1:0]  y_full;                   // Per-group full column

    assign gnt_top_flat = gnt_top_i;
    assign req_o        = req_flat;

    for (genvar gr = 0; gr < GROUPS; gr++)
    begin : g_row
        for (genvar gc = 0; gc < GROUPS; gc++)
        begin : g_col
            localparam int G = gr * GROUPS + gc;                 // Flat group index

            logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] set_grp;      // Slice of set_i
            logic [GROUP_SIZE-1:0][GROUP_SIZE-1:0] gnt_grp;      // Grant of this group
            logic [LOC_W-1:0]                      x_loc;        // Local row
            logic [LOC_W-1:0]                      y_loc;        // Local column

            for (genvar r = 0; r < GROUP_SIZE; r++)
            begin : g_pr
                for (genvar c = 0; c < GROUP_SIZE; c++)
                begin : g_pc
                    // Same tile position in both directions
                    assign set_grp[r][c] = set_i[gr*GROUP_SIZE + r][gc*GROUP_SIZE + c];
                    assign gnt_o_high[gr*GROUP_SIZE + r][gc*GROUP_SIZE + c] = gnt_grp[r][c];
                end
            end

            pixel_group_arbiter #(
                .SIZE           (GROUP_SIZE)
            ) u_arb (
                .clk_i          (clk_i),
                .rst_n_i        (rst_n_i),
                .enable_i       (gnt_top_flat[G]),               // Top grant enables the group
                .req_i          (set_grp),
                .grp_release_i  (grp_release_i),
                .req_o          (req_flat[G]),
                .gnt_o          (gnt_grp),
                .x_add_o        (x_loc),
                .y_add_o        (y_loc),
                .active_o       (act_flat[G]),
                .grp_release_o  (rel_flat[G])
            );

            // Group origin plus local offset
            assign x_full[G] = ADD_W'(gr * GROUP_SIZE) + ADD_W'(x_loc);
            assign y_full[G] = ADD_W'(gc * GROUP_SIZE) + ADD_W'(y_loc);
        end
    end

    assign active_o = |act_flat;                                 // Only the enabled group can be active

    // Top grant is one-hot, so at most one group is selected
    always_comb
    begin
        x_add_o       = '0;
        y_add_o       = '0;
        grp_release_o = 1'b0;
        for (int g = 0; g < NUM_GROUPS; g++)
        begin
            if (gnt_top_flat[g])
            begin
                x_add_o       = x_full[g];
                y_add_o       = y_full[g];
                grp_release_o = rel_flat[g];
            end
        end
    end

endmodule : pixel_groups_l1

`default_nettype wire

//--- rtl/pixel_group_arbiter.sv
/*
 * Round-robin arbiter over a square request matrix
 *  - picks the next request after the last grant in row-major order
 *  - holds the one-hot grant and local row/column address until release
 *  - flags group release when no other request remains
 *  - serves both the pixel groups and the group level above
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_group_arbiter #(
    parameter  int SIZE  = lib_arbiter_pkg::GROUP_SIZE_DEF, // Side of the request matrix
    localparam int ADD_W = (SIZE > 1) ? $clog2(SIZE) : 1    // Local address width
) (
    input  wire logic                       clk_i,          // Clock
    input  wire logic                       rst_n_i,        // Async reset, active low
    input  wire logic                       enable_i,       // Grant from the level above
    input  wire logic [SIZE-1:0][SIZE-1:0]  req_i,          // Request matrix
    input  wire logic                       grp_release_i,  // Release of the held grant
    output logic                            req_o,          // Any request pending
    output logic      [SIZE-1:0][SIZE-1:0]  gnt_o,          // One-hot grant matrix
    output logic      [ADD_W-1:0]           x_add_o,        // Row of the granted request
    output logic      [ADD_W-1:0]           y_add_o,        // Column of the granted request
    output logic                            active_o,       // Grant held
    output logic                            grp_release_o   // Last request of this matrix done
);

    import lib_arbiter_pkg::*;

    localparam int N     = SIZE * SIZE;                 // Requests in the matrix
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;     // Flat index width

    arb_state_e        state_q;                         // FSM state
    arb_state_e        state_d;
    logic [N-1:0]      gnt_q;                           // Registered one-hot grant
    logic [N-1:0]      gnt_d;
    logic [IDX_W-1:0]  ptr_q;                           // Index granted last
    logic [IDX_W-1:0]  ptr_d;
    logic [N-1:0]      req_flat;                        // Requests, bit r*SIZE+c
    logic [IDX_W-1:0]  pick;                            // Next index in round-robin order
    logic              found;                           // Search hit

    assign req_flat = req_i;                            // Packed matrix is row-major already

    // Search starts just after the last grant and wraps once
    always_comb
    begin
        int cand;

        pick  = ptr_q;
        found = 1'b0;
        for (int i = 1; i <= N; i++)
        begin
            cand = int'(ptr_q) + i;
            if (cand >= N)
                cand = cand - N;                        // Wrap to row 0
            if (!found && req_flat[cand])
            begin
                found = 1'b1;                           // First hit wins
                pick  = IDX_W'(cand);
            end
        end
    end

    always_comb
    begin
        state_d = state_q;
        gnt_d   = gnt_q;
        ptr_d   = ptr_q;
        case (state_q)
            ARB_IDLE:
            begin
                if (enable_i && found)                  // Enabled and something to serve
                begin
                    gnt_d       = '0;
                    gnt_d[pick] = 1'b1;                 // One-hot grant
                    ptr_d       = pick;                 // Remember for round-robin
                    state_d     = ARB_GRANT;
                end
            end
            ARB_GRANT:
            begin
                if (grp_release_i)
                begin
                    gnt_d   = '0;                       // Released on the first cycle
                    state_d = ARB_IDLE;
                end
                else
                begin
                    state_d = ARB_WAIT;
                end
            end
            ARB_WAIT:
            begin
                if (grp_release_i)
                begin
                    gnt_d   = '0;                       // Re-arbitrate from idle next cycle
                    state_d = ARB_IDLE;
                end
            end
            default:
            begin
                gnt_d   = '0;                           // Unused encoding recovers to idle
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= ARB_IDLE;
            gnt_q   <= '0;
            ptr_q   <= IDX_W'(N - 1);                   // First search starts at index 0
        end
        else
        begin
            state_q <= state_d;
            gnt_q   <= gnt_d;
            ptr_q   <= ptr_d;
        end
    end

    assign req_o    = |req_flat;                        // Request to the level above
    assign gnt_o    = gnt_q;
    assign active_o = (state_q != ARB_IDLE);
    assign x_add_o  = ADD_W'(ptr_q / SIZE);             // Pointer holds the granted index
    assign y_add_o  = ADD_W'(ptr_q % SIZE);

    // Only the granted request is left, so the level above may move on
    assign grp_release_o = grp_release_i & active_o & ~(|(req_flat & ~gnt_q));

endmodule : pixel_group_arbiter

`default_nettype wire

//--- rtl/pixel_event_latch.sv
/*
 * Sticky per-pixel event register
 *  - one pending bit per pixel, set by a one-cycle event pulse
 *  - cleared by the pixel grant on an acknowledge cycle
 *  - a pulse coinciding with the clear keeps the pixel pending
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_event_latch #(
    parameter int PIXELS = lib_arbiter_pkg::PIXELS_DEF  // Pixels per array side
) (
    input  wire logic                           clk_i,      // Clock
    input  wire logic                           rst_n_i,    // Async reset, active low
    input  wire logic [PIXELS-1:0][PIXELS-1:0]  event_i,    // Event pulses from the array
    input  wire logic [PIXELS-1:0][PIXELS-1:0]  clear_i,    // Grant matrix of the read pixel
    input  wire logic                           ack_i,      // Reader acknowledge
    output logic      [PIXELS-1:0][PIXELS-1:0]  pending_o   // Pending events to arbitration
);

    localparam int N = PIXELS * PIXELS;                 // Total pixel count

    logic [N-1:0] pending_q;                            // Sticky event bits, row-major
    logic [N-1:0] retire;                               // Pixels read out this cycle

    // The grant alone does not retire a pixel, only the handshake does
    assign retire = ack_i ? clear_i : '0;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pending_q <= '0;                            // Nothing pending after reset
        end
        else
        begin
            // New pulse is ORed last so it wins over the clear
            pending_q <= (pending_q & ~retire) | event_i;
        end
    end

    assign pending_o = pending_q;                       // Flat bits map back to [row][col]

endmodule : pixel_event_latch

`default_nettype wire

//--- rtl/lib_arbiter_pkg.sv
/*
 * Shared definitions of the pixel readout arbiter
 *  - default side length of the pixel array
 *  - default side length of one arbitration group
 *  - state encoding of the group arbiter FSM
 */
`default_nettype none

package lib_arbiter_pkg;

    // Default geometry, overridden from the top level
    localparam int PIXELS_DEF     = 8;                  // Pixels per array side
    localparam int GROUP_SIZE_DEF = 4;                  // Pixels per group side

    // Group arbiter FSM
    // GRANT lasts one cycle after a new choice, WAIT holds it until release
    typedef enum logic [1:0]
    {
        ARB_IDLE  = 2'd0,                               // No grant, looking for requests
        ARB_GRANT = 2'd1,                               // Grant issued this cycle
        ARB_WAIT  = 2'd2                                // Grant held, waiting for release
    } arb_state_e;

endpackage : lib_arbiter_pkg

`default_nettype wire
